/* logic/reset_sequencer.sv */
////////////////////////////////////////
// Power-good and core reset sequencing
// Runs the power-up sequence after reset_i and on hard requests,
// holds only the core reset low on warm requests
////////////////////////////////////////

module reset_sequencer
    import soc_ctrl_pkg::*;
#(
    parameter int PWRGOOD_DELAY = 5,
    parameter int RST_DELAY     = 20
) (
    input  logic       core_clk,
    input  logic       reset_i,
    input  reset_req_t reset_req_i,
    output logic       pwrgood_o,
    output logic       rst_b_o,
    output logic       seq_done_o
);

    // Counter wide enough for the longer of the two delays
    localparam int MAX_DELAY = (PWRGOOD_DELAY > RST_DELAY) ? PWRGOOD_DELAY : RST_DELAY;
    localparam int CNT_W     = $clog2(MAX_DELAY + 1);

    typedef enum logic [2:0] {
        ST_OFF,
        ST_PWRUP_WAIT,
        ST_RST_WAIT,
        ST_RUN,
        ST_WARM_HOLD
    } seq_state_e;

    seq_state_e       state;
    logic [CNT_W-1:0] dly_cnt;
    logic             pwr_done;
    logic             rst_done;

    // Terminal counts, counter starts at 0 on state entry
    assign pwr_done = (dly_cnt == CNT_W'(PWRGOOD_DELAY - 1));
    assign rst_done = (dly_cnt == CNT_W'(RST_DELAY - 1));

    ////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////

    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            state      <= ST_OFF;
            dly_cnt    <= '0;
            pwrgood_o  <= 1'b0;
            rst_b_o    <= 1'b0;
            seq_done_o <= 1'b0;
        end else begin
            // Done strobe lasts a single cycle
            seq_done_o <= 1'b0;
            case (state)
                // Both rails low, first cycle of the power-good delay
                ST_OFF, ST_PWRUP_WAIT: begin
                    if (pwr_done) begin
                        state     <= ST_RST_WAIT;
                        dly_cnt   <= '0;
                        pwrgood_o <= 1'b1;
                    end else begin
                        state   <= ST_PWRUP_WAIT;
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                // Power-up release and warm hold share the same timing
                ST_RST_WAIT, ST_WARM_HOLD: begin
                    if (rst_done) begin
                        state      <= ST_RUN;
                        dly_cnt    <= '0;
                        rst_b_o    <= 1'b1;
                        seq_done_o <= 1'b1;
                    end else begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end
                end
                // Only place a request is taken, hard wins over warm
                ST_RUN: begin
                    if (reset_req_i.hard_req) begin
                        state     <= ST_OFF;
                        dly_cnt   <= '0;
                        pwrgood_o <= 1'b0;
                        rst_b_o   <= 1'b0;
                    end else if (reset_req_i.warm_req) begin
                        state   <= ST_WARM_HOLD;
                        dly_cnt <= '0;
                        rst_b_o <= 1'b0;
                    end
                end
                default: begin
                    state     <= ST_OFF;
                    dly_cnt   <= '0;
                    pwrgood_o <= 1'b0;
                    rst_b_o   <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* logic/soc_ctrl_pkg.sv */
////////////////////////////////////////
// Shared widths and bundled types for the SoC control block
// Imported by every module that moves straps, resets or trace data
////////////////////////////////////////

package soc_ctrl_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // One MCU trace word
    parameter int TRACE_DATA_W = 32;
    // Warm reset epoch tag, wraps silently
    parameter int EPOCH_W = 4;
    // One bus-user strap word
    parameter int STRAP_W = 32;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // Host reset strobes, one cycle each
    typedef struct packed {
        logic hard_req;
        logic warm_req;
    } reset_req_t;

    // Raw strap pins plus the two override bits
    typedef struct packed {
        logic [STRAP_W-1:0] lsu_user;
        logic [STRAP_W-1:0] ifu_user;
        logic [STRAP_W-1:0] dma_user;
        logic [STRAP_W-1:0] sram_cfg_user;
        logic [STRAP_W-1:0] soc_cfg_user;
        // Clear means take the DMA word
        logic               sram_cfg_ovr;
        // Clear means take the LSU word
        logic               soc_cfg_ovr;
    } strap_in_t;

    // Captured strap words after defaulting
    typedef struct packed {
        logic [STRAP_W-1:0] lsu_user;
        logic [STRAP_W-1:0] ifu_user;
        logic [STRAP_W-1:0] dma_user;
        logic [STRAP_W-1:0] sram_cfg_user;
        logic [STRAP_W-1:0] soc_cfg_user;
    } strap_out_t;

    // One ring buffer slot
    typedef struct packed {
        logic [EPOCH_W-1:0]      epoch;
        logic [TRACE_DATA_W-1:0] data;
    } trace_entry_t;

    // Host readout response
    typedef struct packed {
        trace_entry_t entry;
        // Index at or beyond the stored count
        logic         err;
    } trace_rsp_t;

endpackage

/* logic/soc_ctrl_top.sv */
////////////////////////////////////////
// SoC control block top level
// Reset sequencer, strap latch and MCU trace path, sets all delays
// and the trace depth
////////////////////////////////////////

module soc_ctrl_top
    import soc_ctrl_pkg::*;
#(
    parameter int PWRGOOD_DELAY = 5,
    parameter int RST_DELAY     = 20,
    parameter int TRACE_DEPTH   = 256
) (
    input  logic                           core_clk,
    input  logic                           reset_i,
    input  reset_req_t                     reset_req_i,
    input  strap_in_t                      straps_i,
    input  logic                           trace_valid_i,
    input  logic [TRACE_DATA_W-1:0]        trace_data_i,
    input  logic                           rd_req_i,
    input  logic [$clog2(TRACE_DEPTH)-1:0] rd_index_i,
    output logic                           pwrgood_o,
    output logic                           rst_b_o,
    output logic                           seq_done_o,
    output strap_out_t                     straps_o,
    output logic                           rd_valid_o,
    output trace_rsp_t                     rd_rsp_o
);

    localparam int PTR_W = $clog2(TRACE_DEPTH);

    // Producer to buffer
    logic         wr_stb;
    trace_entry_t wr_entry;
    // Buffer to consumer
    logic [PTR_W-1:0] rd_addr;
    trace_entry_t     rd_entry;
    logic [PTR_W-1:0] wr_ptr;
    logic             wrapped;
    logic [PTR_W:0]   count;

    ////////////////////////////////////////
    // Reset and straps
    ////////////////////////////////////////

    reset_sequencer #(
        .PWRGOOD_DELAY (PWRGOOD_DELAY),
        .RST_DELAY     (RST_DELAY)
    ) i_reset_sequencer (
        .core_clk    (core_clk),
        .reset_i     (reset_i),
        .reset_req_i (reset_req_i),
        .pwrgood_o   (pwrgood_o),
        .rst_b_o     (rst_b_o),
        .seq_done_o  (seq_done_o)
    );

    strap_capture i_strap_capture (
        .core_clk  (core_clk),
        .reset_i   (reset_i),
        .pwrgood_i (pwrgood_o),
        .straps_i  (straps_i),
        .straps_o  (straps_o)
    );

    ////////////////////////////////////////
    // Trace path
    ////////////////////////////////////////

    trace_capture i_trace_capture (
        .core_clk      (core_clk),
        .reset_i       (reset_i),
        .pwrgood_i     (pwrgood_o),
        .rst_b_i       (rst_b_o),
        .trace_valid_i (trace_valid_i),
        .trace_data_i  (trace_data_i),
        .wr_stb_o      (wr_stb),
        .wr_entry_o    (wr_entry)
    );

    trace_ring_buffer #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) i_trace_ring_buffer (
        .core_clk   (core_clk),
        .reset_i    (reset_i),
        .wr_stb_i   (wr_stb),
        .wr_entry_i (wr_entry),
        .rd_addr_i  (rd_addr),
        .rd_entry_o (rd_entry),
        .wr_ptr_o   (wr_ptr),
        .wrapped_o  (wrapped),
        .count_o    (count)
    );

    trace_readout #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) i_trace_readout (
        .core_clk   (core_clk),
        .reset_i    (reset_i),
        .rd_req_i   (rd_req_i),
        .rd_index_i (rd_index_i),
        .wr_ptr_i   (wr_ptr),
        .wrapped_i  (wrapped),
        .count_i    (count),
        .rd_addr_o  (rd_addr),
        .rd_entry_i (rd_entry),
        .rd_valid_o (rd_valid_o),
        .rd_rsp_o   (rd_rsp_o)
    );

endmodule

/* logic/strap_capture.sv */
////////////////////////////////////////
// Strap latch, sampled on each power-good rise
// SRAM and SoC config words fall back to DMA and LSU without override
////////////////////////////////////////

module strap_capture
    import soc_ctrl_pkg::*;
(
    input  logic       core_clk,
    input  logic       reset_i,
    input  logic       pwrgood_i,
    input  strap_in_t  straps_i,
    output strap_out_t straps_o
);

    logic       pwrgood_q;
    logic       pwrgood_rise;
    strap_out_t straps_nxt;

    assign pwrgood_rise = pwrgood_i & ~pwrgood_q;

    // Defaulting rules
    always_comb begin
        straps_nxt.lsu_user = straps_i.lsu_user;
        straps_nxt.ifu_user = straps_i.ifu_user;
        straps_nxt.dma_user = straps_i.dma_user;
        // No override, SRAM config follows DMA
        straps_nxt.sram_cfg_user = straps_i.sram_cfg_ovr ? straps_i.sram_cfg_user
                                                         : straps_i.dma_user;
        // No override, SoC config follows LSU
        straps_nxt.soc_cfg_user = straps_i.soc_cfg_ovr ? straps_i.soc_cfg_user
                                                       : straps_i.lsu_user;
    end

    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            pwrgood_q <= 1'b0;
            straps_o  <= '0;
        end else begin
            pwrgood_q <= pwrgood_i;
            // Held until the next rise
            if (pwrgood_rise) begin
                straps_o <= straps_nxt;
            end
        end
    end

endmodule

/* logic/trace_capture.sv */
////////////////////////////////////////
// Trace producer
// Keeps words seen while the core is out of reset, tags them with
// the warm reset epoch and issues one buffer write a cycle later
////////////////////////////////////////

module trace_capture
    import soc_ctrl_pkg::*;
(
    input  logic                    core_clk,
    input  logic                    reset_i,
    input  logic                    pwrgood_i,
    input  logic                    rst_b_i,
    input  logic                    trace_valid_i,
    input  logic [TRACE_DATA_W-1:0] trace_data_i,
    output logic                    wr_stb_o,
    output trace_entry_t            wr_entry_o
);

    logic               rst_b_q;
    logic               rel_rise;
    // Set once the power-up release has been seen
    logic               first_rel;
    logic [EPOCH_W-1:0] epoch;
    logic [EPOCH_W-1:0] epoch_cur;

    assign rel_rise = rst_b_i & ~rst_b_q;

    // Epoch in force this cycle, a warm release counts immediately
    assign epoch_cur = (rel_rise && first_rel) ? epoch + EPOCH_W'(1) : epoch;

    ////////////////////////////////////////
    // Epoch tracking
    ////////////////////////////////////////

    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            rst_b_q   <= 1'b0;
            first_rel <= 1'b0;
            epoch     <= '0;
            wr_stb_o  <= 1'b0;
        end else begin
            rst_b_q <= rst_b_i;
            // Drop anything arriving during core reset
            wr_stb_o <= trace_valid_i & rst_b_i;
            if (!pwrgood_i) begin
                // Power loss starts the count over
                first_rel <= 1'b0;
                epoch     <= '0;
            end else if (rel_rise) begin
                first_rel <= 1'b1;
                epoch     <= epoch_cur;
            end
        end
    end

    // Entry payload, qualified by wr_stb_o
    always_ff @(posedge core_clk) begin
        if (trace_valid_i) begin
            wr_entry_o.epoch <= epoch_cur;
            wr_entry_o.data  <= trace_data_i;
        end
    end

endmodule

/* logic/trace_readout.sv */
////////////////////////////////////////
// Trace consumer
// Maps age-ordered host indices to buffer slots, response two cycles
// after the request, one request per cycle
////////////////////////////////////////

module trace_readout
    import soc_ctrl_pkg::*;
#(
    parameter int TRACE_DEPTH = 256
) (
    input  logic                           core_clk,
    input  logic                           reset_i,
    input  logic                           rd_req_i,
    input  logic [$clog2(TRACE_DEPTH)-1:0] rd_index_i,
    input  logic [$clog2(TRACE_DEPTH)-1:0] wr_ptr_i,
    input  logic                           wrapped_i,
    input  logic [$clog2(TRACE_DEPTH):0]   count_i,
    output logic [$clog2(TRACE_DEPTH)-1:0] rd_addr_o,
    input  trace_entry_t                   rd_entry_i,
    output logic                           rd_valid_o,
    output trace_rsp_t                     rd_rsp_o
);

    localparam int PTR_W = $clog2(TRACE_DEPTH);

    logic s1_valid;
    logic s1_err;
    logic s2_err;
    logic in_range;

    // Count sampled with the request
    assign in_range = ({1'b0, rd_index_i} < count_i);

    ////////////////////////////////////////
    // Stage 1, address map and range check
    ////////////////////////////////////////

    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
            s1_err   <= 1'b0;
        end else begin
            s1_valid <= rd_req_i;
            s1_err   <= rd_req_i & ~in_range;
        end
    end

    // After a wrap the oldest entry sits at the write pointer
    always_ff @(posedge core_clk) begin
        if (rd_req_i) begin
            rd_addr_o <= wrapped_i ? PTR_W'(rd_index_i + wr_ptr_i) : rd_index_i;
        end
    end

    ////////////////////////////////////////
    // Stage 2, response
    ////////////////////////////////////////

    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            rd_valid_o <= 1'b0;
            s2_err     <= 1'b0;
        end else begin
            rd_valid_o <= s1_valid;
            s2_err     <= s1_err;
        end
    end

    // Buffer data lands in this cycle, zeroed for a bad index
    always_comb begin
        rd_rsp_o.err   = s2_err;
        rd_rsp_o.entry = s2_err ? '0 : rd_entry_i;
    end

endmodule

/* logic/trace_ring_buffer.sv */
////////////////////////////////////////
// Circular trace store
// Overwrites the oldest slot once full, keeps contents across
// hard and warm resets, registered read port
////////////////////////////////////////

module trace_ring_buffer
    import soc_ctrl_pkg::*;
#(
    parameter int TRACE_DEPTH = 256
) (
    input  logic                           core_clk,
    input  logic                           reset_i,
    input  logic                           wr_stb_i,
    input  trace_entry_t                   wr_entry_i,
    input  logic [$clog2(TRACE_DEPTH)-1:0] rd_addr_i,
    output trace_entry_t                   rd_entry_o,
    output logic [$clog2(TRACE_DEPTH)-1:0] wr_ptr_o,
    output logic                           wrapped_o,
    output logic [$clog2(TRACE_DEPTH):0]   count_o
);

    localparam int PTR_W = $clog2(TRACE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    trace_entry_t mem [TRACE_DEPTH];
    logic         last_slot;
    logic         full;

    assign last_slot = (wr_ptr_o == PTR_W'(TRACE_DEPTH - 1));
    assign full      = (count_o == CNT_W'(TRACE_DEPTH));

    ////////////////////////////////////////
    // Write side bookkeeping
    ////////////////////////////////////////

    always_ff @(posedge core_clk) begin
        if (reset_i) begin
            wr_ptr_o  <= '0;
            wrapped_o <= 1'b0;
            count_o   <= '0;
        end else if (wr_stb_i) begin
            // Power of two depth, pointer wraps naturally
            wr_ptr_o <= wr_ptr_o + 1'b1;
            if (last_slot) begin
                wrapped_o <= 1'b1;
            end
            // Count stops at depth
            if (!full) begin
                count_o <= count_o + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge core_clk) begin
        if (wr_stb_i) begin
            mem[wr_ptr_o] <= wr_entry_i;
        end
    end

    // Read data one cycle after the address, old data on a collision
    always_ff @(posedge core_clk) begin
        rd_entry_o <= mem[rd_addr_i];
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the SoC control block testbench with Verilator and run it
# Exit status is zero only when the pass line shows up in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module soc_ctrl_tb -Mdir obj_dir -f sources.f &&
./obj_dir/Vsoc_ctrl_tb | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

/* sources.f */
logic/soc_ctrl_pkg.sv
logic/reset_sequencer.sv
logic/strap_capture.sv
logic/trace_capture.sv
logic/trace_ring_buffer.sv
logic/trace_readout.sv
logic/soc_ctrl_top.sv
tests/soc_ctrl_tb.sv

/* tests/soc_ctrl_tb.sv */
////////////////////////////////////////
// Random-stimulus testbench for the SoC control block
// Cycle model of sequencer, straps and trace path checked every cycle
////////////////////////////////////////

module soc_ctrl_tb
    import soc_ctrl_pkg::*;
();

    // Same values as the top level defaults
    localparam int PWRGOOD_DELAY = 5;
    localparam int RST_DELAY     = 20;
    localparam int TRACE_DEPTH   = 256;
    localparam int PTR_W         = $clog2(TRACE_DEPTH);
    localparam int CLK_PERIOD    = 100;

    // Test lengths in cycles
    localparam int N_RAND_A = 300;
    localparam int N_READ_A = 150;
    localparam int N_RAND_B = 3000;
    localparam int N_READ_B = 200;
    // Reset, power-up, settle gaps and the two ordered sweeps
    localparam int N_FIXED  = 5 + PWRGOOD_DELAY + RST_DELAY + 2 * TRACE_DEPTH + 20;
    localparam int N_TOTAL  = N_RAND_A + N_READ_A + N_RAND_B + N_READ_B + N_FIXED;
    localparam int N_MARGIN = 500;

    typedef enum logic [1:0] {
        PH_PWRUP,
        PH_RST,
        PH_RUN,
        PH_WARM
    } seq_phase_e;

    // DUT ports
    logic                    core_clk;
    logic                    reset_i;
    reset_req_t              reset_req;
    strap_in_t               straps_in;
    logic                    trace_valid;
    logic [TRACE_DATA_W-1:0] trace_data;
    logic                    rd_req;
    logic [PTR_W-1:0]        rd_index;
    logic                    pwrgood;
    logic                    rst_b;
    logic                    seq_done;
    strap_out_t              straps_out;
    logic                    rd_valid;
    trace_rsp_t              rd_rsp;

    ////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////

    seq_phase_e         m_phase;
    int                 m_left;
    logic               m_pwrgood;
    logic               m_rst_b;
    logic               m_seq_done;
    logic [EPOCH_W-1:0] m_epoch;
    logic               m_pg_q;
    strap_out_t         m_straps;
    trace_entry_t       m_ring [TRACE_DEPTH];
    int                 m_ptr;
    logic               m_wrapped;
    int                 m_count;
    logic               m_wr_pend;
    trace_entry_t       m_wr_entry;
    // Readout pipeline where stage 2 is what the DUT shows
    logic               s1_valid;
    logic               s1_err;
    trace_entry_t       s1_entry;
    logic               s2_valid;
    logic               s2_err;
    trace_entry_t       s2_entry;

    logic [31:0]        lfsr_state;
    logic               checking;

    soc_ctrl_top i_soc_ctrl_top (
        .core_clk      (core_clk),
        .reset_i       (reset_i),
        .reset_req_i   (reset_req),
        .straps_i      (straps_in),
        .trace_valid_i (trace_valid),
        .trace_data_i  (trace_data),
        .rd_req_i      (rd_req),
        .rd_index_i    (rd_index),
        .pwrgood_o     (pwrgood),
        .rst_b_o       (rst_b),
        .seq_done_o    (seq_done),
        .straps_o      (straps_out),
        .rd_valid_o    (rd_valid),
        .rd_rsp_o      (rd_rsp)
    );

    initial begin
        core_clk = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
    end

    ////////////////////////////////////////
    // Random source and helpers
    ////////////////////////////////////////

    // Right-shift Galois LFSR
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic strap_in_t random_straps();
        strap_in_t s;
        s.lsu_user      = rand_bits(STRAP_W);
        s.ifu_user      = rand_bits(STRAP_W);
        s.dma_user      = rand_bits(STRAP_W);
        s.sram_cfg_user = rand_bits(STRAP_W);
        s.soc_cfg_user  = rand_bits(STRAP_W);
        s.sram_cfg_ovr  = (rand_bits(1) != 32'd0);
        s.soc_cfg_ovr   = (rand_bits(1) != 32'd0);
        return s;
    endfunction

    // Without an override SRAM config takes DMA and SoC config takes LSU
    function automatic strap_out_t apply_straps(input strap_in_t s);
        strap_out_t o;
        o.lsu_user      = s.lsu_user;
        o.ifu_user      = s.ifu_user;
        o.dma_user      = s.dma_user;
        o.sram_cfg_user = s.sram_cfg_ovr ? s.sram_cfg_user : s.dma_user;
        o.soc_cfg_user  = s.soc_cfg_ovr ? s.soc_cfg_user : s.lsu_user;
        return o;
    endfunction

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_eq(input logic [191:0] got, input logic [191:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////
    // Model stepped once per rising edge
    ////////////////////////////////////////

    task automatic model_update();
        int phys;
        if (reset_i) begin
            m_phase    = PH_PWRUP;
            m_left     = PWRGOOD_DELAY;
            m_pwrgood  = 1'b0;
            m_rst_b    = 1'b0;
            m_seq_done = 1'b0;
            m_epoch    = '0;
            m_pg_q     = 1'b0;
            m_straps   = '0;
            m_ptr      = 0;
            m_wrapped  = 1'b0;
            m_count    = 0;
            m_wr_pend  = 1'b0;
            s1_valid   = 1'b0;
            s1_err     = 1'b0;
            s2_valid   = 1'b0;
            s2_err     = 1'b0;
        end else begin
            s2_valid = s1_valid;
            s2_err   = s1_err;
            s2_entry = s1_entry;
            // Range and slot use the state seen with the request
            s1_valid = rd_req;
            s1_err   = rd_req && (int'(rd_index) >= m_count);
            phys     = m_wrapped ? (int'(rd_index) + m_ptr) % TRACE_DEPTH : int'(rd_index);
            // Straps latched on the power-good rise
            if (m_pwrgood && !m_pg_q) begin
                m_straps = apply_straps(straps_in);
            end
            m_pg_q = m_pwrgood;
            // Word accepted last cycle lands now
            if (m_wr_pend) begin
                m_ring[m_ptr] = m_wr_entry;
                if (m_ptr == TRACE_DEPTH - 1) begin
                    m_wrapped = 1'b1;
                end
                m_ptr = (m_ptr + 1) % TRACE_DEPTH;
                if (m_count < TRACE_DEPTH) begin
                    m_count++;
                end
            end
            // Read data includes this edge's write
            s1_entry = s1_err ? '0 : m_ring[phys];
            m_wr_pend        = trace_valid && m_rst_b;
            m_wr_entry.epoch = m_epoch;
            m_wr_entry.data  = trace_data;
            // Sequencer countdowns
            m_seq_done = 1'b0;
            case (m_phase)
                PH_PWRUP: begin
                    m_left = m_left - 1;
                    if (m_left == 0) begin
                        m_pwrgood = 1'b1;
                        m_phase   = PH_RST;
                        m_left    = RST_DELAY;
                    end
                end
                PH_RST, PH_WARM: begin
                    m_left = m_left - 1;
                    if (m_left == 0) begin
                        m_rst_b    = 1'b1;
                        m_seq_done = 1'b1;
                        // Only a warm release opens a new epoch
                        if (m_phase == PH_WARM) begin
                            m_epoch = m_epoch + EPOCH_W'(1);
                        end
                        m_phase = PH_RUN;
                    end
                end
                default: begin
                    if (reset_req.hard_req) begin
                        m_pwrgood = 1'b0;
                        m_rst_b   = 1'b0;
                        m_epoch   = '0;
                        m_phase   = PH_PWRUP;
                        m_left    = PWRGOOD_DELAY;
                    end else if (reset_req.warm_req) begin
                        m_rst_b = 1'b0;
                        m_phase = PH_WARM;
                        m_left  = RST_DELAY;
                    end
                end
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    task automatic clock_edge();
        @(posedge core_clk);
        model_update();
    endtask

    task automatic drive_idle();
        reset_req   <= '0;
        trace_valid <= 1'b0;
        rd_req      <= 1'b0;
    endtask

    task automatic drive_read(input logic [PTR_W-1:0] idx);
        reset_req   <= '0;
        trace_valid <= 1'b0;
        rd_req      <= 1'b1;
        rd_index    <= idx;
    endtask

    // Resets, traces and strap changes with the trace rate set by sparse_bits
    task automatic drive_random(input int sparse_bits);
        reset_req_t  req;
        logic [31:0] pick;
        pick         = rand_bits(6);
        // Hard alone, both together, or warm alone
        req.hard_req = (pick <= 32'd1);
        req.warm_req = (pick >= 32'd1) && (pick <= 32'd4);
        reset_req   <= req;
        trace_valid <= (rand_bits(sparse_bits) == 32'd0);
        trace_data  <= rand_bits(TRACE_DATA_W);
        rd_req      <= 1'b0;
        if (rand_bits(4) == 32'd0) begin
            straps_in <= random_straps();
        end
    endtask

    task automatic settle();
        repeat (4) begin
            clock_edge();
            drive_idle();
        end
    endtask

    // Every output against the model on the falling edge
    always @(negedge core_clk) begin
        if (checking) begin
            check_eq(192'(pwrgood), 192'(m_pwrgood), "pwrgood_o");
            check_eq(192'(rst_b), 192'(m_rst_b), "rst_b_o");
            check_eq(192'(seq_done), 192'(m_seq_done), "seq_done_o");
            check_eq(192'(straps_out), 192'(m_straps), "straps_o");
            check_eq(192'(rd_valid), 192'(s2_valid), "rd_valid_o");
            if (s2_valid) begin
                check_eq(192'(rd_rsp.err), 192'(s2_err), "rd_rsp_o.err");
                check_eq(192'(rd_rsp.entry), 192'(s2_entry), "rd_rsp_o.entry");
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        lfsr_state  = 32'hf4a7_f459;
        checking    = 1'b0;
        reset_i     = 1'b1;
        reset_req   = '0;
        straps_in   = random_straps();
        trace_valid = 1'b0;
        trace_data  = '0;
        rd_req      = 1'b0;
        rd_index    = '0;
        repeat (5) begin
            clock_edge();
            checking = 1'b1;
        end
        reset_i <= 1'b0;

        // Initial power-up timed from the delays alone
        repeat (PWRGOOD_DELAY - 1) clock_edge();
        @(negedge core_clk);
        check_eq(192'(pwrgood), 192'(1'b0), "pwrgood_o before its delay");
        clock_edge();
        @(negedge core_clk);
        check_eq(192'(pwrgood), 192'(1'b1), "pwrgood_o after its delay");
        repeat (RST_DELAY - 1) clock_edge();
        @(negedge core_clk);
        check_eq(192'(rst_b), 192'(1'b0), "rst_b_o before its delay");
        clock_edge();
        @(negedge core_clk);
        check_eq(192'(rst_b), 192'(1'b1), "rst_b_o after its delay");
        check_eq(192'(seq_done), 192'(1'b1), "seq_done_o with the release");

        // Sparse traces keep the buffer short of full
        repeat (N_RAND_A) begin
            clock_edge();
            drive_random(2);
        end
        settle();
        // Full index sweep with the upper part beyond the count
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            clock_edge();
            drive_read(PTR_W'(i));
        end
        repeat (N_READ_A) begin
            clock_edge();
            drive_read(PTR_W'(rand_bits(7)));
        end
        settle();

        // Dense traces enough to wrap the buffer
        repeat (N_RAND_B) begin
            clock_edge();
            drive_random(1);
        end
        settle();
        if (!m_wrapped) begin
            $display("ERROR: dense trace phase wrote fewer words than the buffer depth");
            stop_with_failure();
        end
        // Age order after the wrap then random back-to-back reads
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            clock_edge();
            drive_read(PTR_W'(i));
        end
        repeat (N_READ_B) begin
            clock_edge();
            drive_read(PTR_W'(rand_bits(PTR_W)));
        end
        settle();

        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #((N_TOTAL + N_MARGIN) * CLK_PERIOD);
        $display("ERROR: timeout, the test sequence did not complete in the expected time");
        stop_with_failure();
    end

endmodule
